// File: filelist.f
+incdir+hdl
hdl/ip_rewrite_tx_pkg.sv
hdl/tx_buf_wr_if.sv
hdl/ip_rewrite_tx_lookup.sv
hdl/ip_rewrite_tx_ctrl.sv
hdl/ip_rewrite_tx_datap.sv
hdl/ip_rewrite_tx_buf.sv
hdl/ip_rewrite_tx_top.sv
verification/ip_rewrite_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the IP rewrite TX testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
TOP=ip_rewrite_tx_tb

if ! verilator --binary --timing --assert -Wno-fatal -f filelist.f \
        --top-module "$TOP" -Mdir "$BUILD_DIR"; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^test passed$" "$LOG"; then
    exit 0
fi

echo "pass line missing from $LOG"
exit 1

// File: verification/ip_rewrite_tx_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ip_rewrite_tx_defs.svh"

module ip_rewrite_tx_tb;
    import ip_rewrite_tx_pkg::*;

    localparam int NUM_RAND1      = 20;
    localparam int NUM_RAND2      = 12;
    localparam int NUM_REQ        = 5 + NUM_RAND1 + NUM_RAND2;   // plus five directed ones.
    localparam int TIMEOUT_CYCLES = NUM_REQ * 40 + 200;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      cfg_val;
    logic [`FLOW_ID_W-1:0]     cfg_flow_id;
    logic [31:0]               cfg_src_ip;
    logic                      req_val;
    tx_req_t                   req;
    logic                      req_rdy;
    logic                      noc_out_val;
    noc_msg_t                  noc_out_msg;
    logic                      noc_out_rdy;
    logic                      noc_in_val;
    logic [`TX_BUF_ADDR_W-1:0] noc_in_addr;
    logic                      noc_in_rdy;
    logic [`TX_BUF_ADDR_W-1:0] rd_addr;
    tx_buf_entry_t             rd_entry;

    logic [31:0]   lfsr_state = 32'hd6ab;
    logic          model_vld [`RW_TABLE_DEPTH];
    logic [31:0]   model_src [`RW_TABLE_DEPTH];
    tx_buf_entry_t exp_q [$];                  // accepted requests, oldest first.
    int            sent_cnt = 0;
    int            done_cnt = 0;
    int            cycle_cnt = 0;

    ip_rewrite_tx_top u_dut (.*);

    always #10 clk = ~clk;

    // ####################
    // random source
    // ####################
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // ####################
    // reference model
    // ####################
    // full one's-complement sum over the summary words.
    function automatic logic [15:0] full_csum(input ip_hdr_t h);
        logic [19:0] sum;
        sum = {4'b0, h.src_ip[31:16]} + {4'b0, h.src_ip[15:0]} + {4'b0, h.dst_ip[31:16]}
            + {4'b0, h.dst_ip[15:0]} + {4'b0, h.length};
        sum = {4'b0, sum[15:0]} + {16'b0, sum[19:16]};
        sum = {4'b0, sum[15:0]} + {16'b0, sum[19:16]};
        return ~sum[15:0];
    endfunction

    function automatic ip_hdr_t expected_hdr(input ip_hdr_t h, input logic hit,
                                             input logic [31:0] new_src);
        ip_hdr_t r;
        r = h;
        if (hit) begin
            r.src_ip   = new_src;
            r.checksum = full_csum(r);    // same as the incremental update.
        end
        return r;
    endfunction

    function automatic noc_msg_t expected_msg(input noc_msg_type_e kind,
                                              input logic [`FLOW_ID_W-1:0] flow,
                                              input logic [15:0] value);
        noc_msg_t m;
        m.msg_type = kind;
        m.flow_id  = flow;
        m.value    = value;
        return m;
    endfunction

    // ####################
    // checks
    // ####################
    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_noc_msg(input string name, input noc_msg_t exp, input noc_msg_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_entry(input string name, input tx_buf_entry_t exp,
                               input tx_buf_entry_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("run timed out with %0d of %0d requests done", done_cnt, sent_cnt);
            stop_run();
        end
    end

    // ####################
    // stimulus
    // ####################
    task automatic write_cfg(input logic [`FLOW_ID_W-1:0] flow, input logic [31:0] ip);
        cfg_val     = 1'b1;
        cfg_flow_id = flow;
        cfg_src_ip  = ip;
        @(posedge clk);
        #2;
        cfg_val         = 1'b0;
        model_vld[flow] = 1'b1;
        model_src[flow] = ip;
    endtask

    task automatic send_one(input logic [`FLOW_ID_W-1:0] flow);
        tx_req_t       r;
        tx_buf_entry_t e;
        logic          acc;
        int            gap;
        r.flow_id      = flow;
        r.hdr.src_ip   = rand_bits(32);
        r.hdr.dst_ip   = rand_bits(32);
        r.hdr.length   = 16'(rand_bits(16));
        r.hdr.checksum = full_csum(r.hdr);
        e.flow_id      = flow;
        e.hdr          = expected_hdr(r.hdr, model_vld[flow], model_src[flow]);
        req            = r;
        req_val        = 1'b1;
        acc            = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc = req_rdy;
            @(posedge clk);
            #2;
        end
        exp_q.push_back(e);
        sent_cnt = sent_cnt + 1;
        req_val  = 1'b0;
        gap      = int'(rand_bits(2));
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_random(input int n);
        logic [31:0] tmp;
        repeat (n) begin
            tmp = rand_bits(`FLOW_ID_W);
            send_one(tmp[`FLOW_ID_W-1:0]);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
        repeat (2) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        rst         = 1'b1;
        cfg_val     = 1'b0;
        cfg_flow_id = '0;
        cfg_src_ip  = '0;
        req_val     = 1'b0;
        req         = '0;
        for (int i = 0; i < `RW_TABLE_DEPTH; i++) begin
            model_vld[i] = 1'b0;
            model_src[i] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        if (noc_out_val !== 1'b0 || noc_in_rdy !== 1'b0) begin
            $display("NoC valid or ready is high right after reset");
            stop_run();
        end

        for (int i = 0; i < 8; i++) begin
            write_cfg(i[`FLOW_ID_W-1:0], rand_bits(32));    // lower half of the flows hit.
        end
        send_one(4'd2);
        send_one(4'd12);
        send_random(NUM_RAND1);
        wait_drain();

        write_cfg(4'd3, rand_bits(32));    // new address for a known flow.
        write_cfg(4'd9, rand_bits(32));
        send_one(4'd3);
        send_one(4'd9);
        send_one(4'd5);
        send_random(NUM_RAND2);
        wait_drain();

        if (noc_out_val === 1'b0 && noc_in_rdy === 1'b0 && req_rdy === 1'b1) begin
            $display("test passed");
            $finish;
        end
        else begin
            $display("DUT not idle after %0d of %0d requests completed", done_cnt, NUM_REQ);
            stop_run();
        end
    end

    // ####################
    // NoC responder
    // ####################
    initial begin : noc_responder
        logic                      out_fire;
        logic                      in_fire;
        logic                      next_rdy;
        logic                      await_ptr;
        logic                      notif_wait;
        logic                      notif_taken;
        int                        notif_delay;
        logic [`TX_BUF_ADDR_W-1:0] addr_cnt;
        logic [`TX_BUF_ADDR_W-1:0] sent_addr;
        tx_buf_entry_t             head;
        noc_out_rdy = 1'b0;
        noc_in_val  = 1'b0;
        noc_in_addr = '0;
        rd_addr     = '0;
        await_ptr   = 1'b0;
        notif_wait  = 1'b0;
        notif_taken = 1'b0;
        notif_delay = 0;
        addr_cnt    = 4'hc;                // wraps early.
        sent_addr   = '0;
        forever begin
            @(negedge clk);
            out_fire = noc_out_val && noc_out_rdy;
            in_fire  = noc_in_val && noc_in_rdy;
            if (in_fire) begin
                notif_taken = 1'b1;
            end
            if (out_fire) begin
                if (exp_q.size() == 0) begin
                    $display("NoC message sent with no request open");
                    stop_run();
                end
                head = exp_q[0];
                if (!await_ptr) begin
                    check_noc_msg($sformatf("tx_req %0d", done_cnt),
                                  expected_msg(TX_REQ, head.flow_id, head.hdr.length),
                                  noc_out_msg);
                    await_ptr   = 1'b1;
                    notif_wait  = 1'b1;
                    notif_delay = int'(rand_bits(3));
                end
                else begin
                    if (!notif_taken) begin
                        $display("tail update sent before the notification was taken");
                        stop_run();
                    end
                    check_noc_msg($sformatf("ptr_update %0d", done_cnt),
                                  expected_msg(PTR_UPDATE, head.flow_id,
                                      16'((int'(sent_addr) + 1) % `TX_BUF_DEPTH)),
                                  noc_out_msg);
                    check_entry($sformatf("entry %0d", done_cnt), head, rd_entry);
                    void'(exp_q.pop_front());
                    await_ptr   = 1'b0;
                    notif_taken = 1'b0;
                    done_cnt    = done_cnt + 1;
                end
            end
            next_rdy = |rand_bits(2);      // ready three cycles in four.
            @(posedge clk);
            #2;
            noc_out_rdy = next_rdy;
            if (in_fire) begin
                noc_in_val = 1'b0;
                addr_cnt   = addr_cnt + 4'd1;
            end
            else if (notif_wait) begin
                if (notif_delay == 0) begin
                    noc_in_val  = 1'b1;
                    noc_in_addr = addr_cnt;
                    rd_addr     = addr_cnt;
                    sent_addr   = addr_cnt;
                    notif_wait  = 1'b0;
                end
                else begin
                    notif_delay = notif_delay - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/ip_rewrite_tx_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "ip_rewrite_tx_defs.svh"

module ip_rewrite_tx_top (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        cfg_val,
    input  wire logic [`FLOW_ID_W-1:0]       cfg_flow_id,
    input  wire logic [31:0]                 cfg_src_ip,
    input  wire logic                        req_val,
    input  ip_rewrite_tx_pkg::tx_req_t       req,
    output logic                             req_rdy,
    output logic                             noc_out_val,
    output ip_rewrite_tx_pkg::noc_msg_t      noc_out_msg,
    input  wire logic                        noc_out_rdy,
    input  wire logic                        noc_in_val,
    input  wire logic [`TX_BUF_ADDR_W-1:0]   noc_in_addr,
    output logic                             noc_in_rdy,
    input  wire logic [`TX_BUF_ADDR_W-1:0]   rd_addr,
    output ip_rewrite_tx_pkg::tx_buf_entry_t rd_entry
);
    import ip_rewrite_tx_pkg::*;

    logic        lk_val;
    logic        lk_rdy;
    tx_req_t     lk_req;
    logic        store_inputs;
    logic        store_notif;
    tx_noc_sel_e noc_sel;

    tx_buf_wr_if u_buf_wr_if ();

    ip_rewrite_tx_lookup u_lookup (
        .clk(clk), .rst(rst),
        .cfg_val(cfg_val), .cfg_flow_id(cfg_flow_id), .cfg_src_ip(cfg_src_ip),
        .in_val(req_val), .in_req(req), .in_rdy(req_rdy),
        .out_val(lk_val), .out_req(lk_req), .out_rdy(lk_rdy)
    );

    ip_rewrite_tx_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .in_val(lk_val), .in_rdy(lk_rdy),
        .noc_out_val(noc_out_val), .noc_out_rdy(noc_out_rdy),
        .noc_in_val(noc_in_val), .noc_in_rdy(noc_in_rdy),
        .store_inputs(store_inputs), .store_notif(store_notif), .noc_sel(noc_sel),
        .buf_wr(u_buf_wr_if.writer)
    );

    ip_rewrite_tx_datap u_datap (
        .clk(clk), .rst(rst),
        .in_req(lk_req), .store_inputs(store_inputs),
        .noc_in_addr(noc_in_addr), .store_notif(store_notif),
        .noc_sel(noc_sel), .noc_out_msg(noc_out_msg),
        .buf_wr(u_buf_wr_if.datap)
    );

    ip_rewrite_tx_buf u_buf (
        .clk(clk), .rst(rst),
        .buf_wr(u_buf_wr_if.buffer),
        .rd_addr(rd_addr), .rd_entry(rd_entry)
    );

endmodule

`default_nettype wire

// File: hdl/ip_rewrite_tx_buf.sv
`timescale 1ns/10ps
`default_nettype none

`include "ip_rewrite_tx_defs.svh"

module ip_rewrite_tx_buf (
    input  wire logic                       clk,
    input  wire logic                       rst,
    tx_buf_wr_if.buffer                     buf_wr,
    input  wire logic [`TX_BUF_ADDR_W-1:0]  rd_addr,
    output ip_rewrite_tx_pkg::tx_buf_entry_t rd_entry
);
    import ip_rewrite_tx_pkg::*;

    tx_buf_entry_t             mem [`TX_BUF_DEPTH];
    logic [`TX_BUF_ADDR_W-1:0] wr_addr_r;
    logic                      wr_pend;    // address taken, beat not yet.
    logic                      done_r;

    assign buf_wr.req_rdy  = ~wr_pend & ~done_r;
    assign buf_wr.data_rdy = wr_pend;
    assign buf_wr.done     = done_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_pend <= 1'b0;
            done_r  <= 1'b0;
        end
        else begin
            if (buf_wr.req_val && buf_wr.req_rdy) begin
                wr_pend <= 1'b1;
            end
            else if (buf_wr.data_val && buf_wr.data_rdy) begin
                wr_pend <= 1'b0;
                done_r  <= 1'b1;
            end
            else if (done_r && buf_wr.done_rdy) begin
                done_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (buf_wr.req_val && buf_wr.req_rdy) begin
            wr_addr_r <= buf_wr.req_addr;
        end
        if (buf_wr.data_val && buf_wr.data_rdy) begin
            mem[wr_addr_r] <= buf_wr.data;
        end
    end

    assign rd_entry = mem[rd_addr];

    a_single_beat: assert property (@(posedge clk) disable iff (rst)
        buf_wr.data_val && buf_wr.data_rdy |-> buf_wr.data_last);

endmodule

`default_nettype wire

// File: hdl/ip_rewrite_tx_datap.sv
`timescale 1ns/10ps
`default_nettype none

`include "ip_rewrite_tx_defs.svh"

module ip_rewrite_tx_datap (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  ip_rewrite_tx_pkg::tx_req_t      in_req,
    input  wire logic                       store_inputs,
    input  wire logic [`TX_BUF_ADDR_W-1:0]  noc_in_addr,
    input  wire logic                       store_notif,
    input  ip_rewrite_tx_pkg::tx_noc_sel_e  noc_sel,
    output ip_rewrite_tx_pkg::noc_msg_t     noc_out_msg,
    tx_buf_wr_if.datap                      buf_wr
);
    import ip_rewrite_tx_pkg::*;

    tx_req_t                   req_r;
    logic [`TX_BUF_ADDR_W-1:0] notif_addr_r;
    logic [`TX_BUF_ADDR_W-1:0] next_tail;

    // ####################
    // stored state
    // ####################
    always_ff @(posedge clk) begin
        if (store_inputs) begin
            req_r <= in_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            notif_addr_r <= '0;
        end
        else if (store_notif) begin
            notif_addr_r <= noc_in_addr;
        end
    end

    // depth is a power of two, so the add wraps at the buffer end.
    assign next_tail = notif_addr_r + 1'b1;

    // ####################
    // outgoing message
    // ####################
    always_comb begin
        noc_out_msg.flow_id = req_r.flow_id;
        if (noc_sel == SEL_PTR_UPDATE) begin
            noc_out_msg.msg_type = PTR_UPDATE;
            noc_out_msg.value    = {{(16-`TX_BUF_ADDR_W){1'b0}}, next_tail};
        end
        else begin
            noc_out_msg.msg_type = TX_REQ;
            noc_out_msg.value    = req_r.hdr.length;
        end
    end

    assign buf_wr.req_addr     = notif_addr_r;
    assign buf_wr.data.flow_id = req_r.flow_id;
    assign buf_wr.data.hdr     = req_r.hdr;

endmodule

`default_nettype wire

// File: hdl/ip_rewrite_tx_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ip_rewrite_tx_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       in_val,
    output logic                            in_rdy,
    output logic                            noc_out_val,
    input  wire logic                       noc_out_rdy,
    input  wire logic                       noc_in_val,
    output logic                            noc_in_rdy,
    output logic                            store_inputs,
    output logic                            store_notif,
    output ip_rewrite_tx_pkg::tx_noc_sel_e  noc_sel,
    tx_buf_wr_if.writer                     buf_wr
);
    import ip_rewrite_tx_pkg::*;

    typedef enum logic [2:0] {
        WAITING_INPUT  = 3'd0,
        TX_SEND_REQ    = 3'd1,
        TX_WAIT_NOTIF  = 3'd2,
        SEND_WR_REQ    = 3'd3,
        SEND_WR_DATA   = 3'd4,
        WAIT_DONE      = 3'd5,
        ADJUST_TX_TAIL = 3'd6
    } state_e;

    state_e state_reg;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= WAITING_INPUT;
        end
        else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        in_rdy           = 1'b0;
        noc_out_val      = 1'b0;
        noc_in_rdy       = 1'b0;
        store_inputs     = 1'b0;
        store_notif      = 1'b0;
        noc_sel          = SEL_TX_REQ;
        buf_wr.req_val   = 1'b0;
        buf_wr.data_val  = 1'b0;
        buf_wr.data_last = 1'b0;
        buf_wr.done_rdy  = 1'b0;
        state_next       = state_reg;

        case (state_reg)
            WAITING_INPUT: begin
                in_rdy = 1'b1;
                if (in_val) begin
                    store_inputs = 1'b1;
                    state_next   = TX_SEND_REQ;
                end
            end
            TX_SEND_REQ: begin
                noc_out_val = 1'b1;
                if (noc_out_rdy) begin
                    state_next = TX_WAIT_NOTIF;
                end
            end
            TX_WAIT_NOTIF: begin
                noc_in_rdy = 1'b1;
                if (noc_in_val) begin
                    store_notif = 1'b1;    // buffer address from the notification.
                    state_next  = SEND_WR_REQ;
                end
            end
            SEND_WR_REQ: begin
                buf_wr.req_val = 1'b1;
                if (buf_wr.req_rdy) begin
                    state_next = SEND_WR_DATA;
                end
            end
            SEND_WR_DATA: begin
                buf_wr.data_val  = 1'b1;
                buf_wr.data_last = 1'b1;   // single beat per header.
                if (buf_wr.data_rdy) begin
                    state_next = WAIT_DONE;
                end
            end
            WAIT_DONE: begin
                buf_wr.done_rdy = 1'b1;
                if (buf_wr.done) begin
                    state_next = ADJUST_TX_TAIL;
                end
            end
            ADJUST_TX_TAIL: begin
                noc_out_val = 1'b1;
                noc_sel     = SEL_PTR_UPDATE;
                if (noc_out_rdy) begin
                    state_next = WAITING_INPUT;
                end
            end
            default: begin
                state_next = WAITING_INPUT;
            end
        endcase
    end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state_reg inside {WAITING_INPUT, TX_SEND_REQ, TX_WAIT_NOTIF, SEND_WR_REQ,
                          SEND_WR_DATA, WAIT_DONE, ADJUST_TX_TAIL});

endmodule

`default_nettype wire

// File: hdl/ip_rewrite_tx_lookup.sv
`timescale 1ns/10ps
`default_nettype none

`include "ip_rewrite_tx_defs.svh"

module ip_rewrite_tx_lookup (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      cfg_val,
    input  wire logic [`FLOW_ID_W-1:0]     cfg_flow_id,
    input  wire logic [31:0]               cfg_src_ip,
    input  wire logic                      in_val,
    input  ip_rewrite_tx_pkg::tx_req_t     in_req,
    output logic                           in_rdy,
    output logic                           out_val,
    output ip_rewrite_tx_pkg::tx_req_t     out_req,
    input  wire logic                      out_rdy
);
    import ip_rewrite_tx_pkg::*;

    logic [`RW_TABLE_DEPTH-1:0] tbl_vld;
    logic [31:0]                tbl_src [`RW_TABLE_DEPTH];
    logic                       hit;
    tx_req_t                    rw_req;

    // RFC 1624 form: ~(~hc + ~m + m'), m taken as two 16-bit halves.
    function automatic logic [15:0] csum_update(
        input logic [15:0] old_csum,
        input logic [31:0] old_ip,
        input logic [31:0] new_ip
    );
        logic [15:0] nc;
        logic [15:0] nh;
        logic [15:0] nl;
        logic [18:0] sum;
        logic [16:0] fold;
        logic [15:0] res;
        nc   = ~old_csum;
        nh   = ~old_ip[31:16];
        nl   = ~old_ip[15:0];
        sum  = {3'b0, nc} + {3'b0, nh} + {3'b0, nl}
             + {3'b0, new_ip[31:16]} + {3'b0, new_ip[15:0]};
        fold = {1'b0, sum[15:0]} + {14'b0, sum[18:16]};   // end-around carries.
        res  = fold[15:0] + {15'b0, fold[16]};
        return ~res;
    endfunction

    // ####################
    // rewrite table
    // ####################
    always_ff @(posedge clk) begin
        if (rst) begin
            tbl_vld <= '0;
        end
        else if (cfg_val) begin
            tbl_vld[cfg_flow_id] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_val) begin
            tbl_src[cfg_flow_id] <= cfg_src_ip;
        end
    end

    assign hit = tbl_vld[in_req.flow_id];

    always_comb begin
        rw_req = in_req;
        if (hit) begin
            rw_req.hdr.src_ip   = tbl_src[in_req.flow_id];
            rw_req.hdr.checksum = csum_update(in_req.hdr.checksum, in_req.hdr.src_ip,
                                              tbl_src[in_req.flow_id]);
        end
    end

    // ####################
    // output register
    // ####################
    assign in_rdy = ~out_val | out_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_val <= 1'b0;
        end
        else if (in_rdy) begin
            out_val <= in_val;
        end
    end

    always_ff @(posedge clk) begin
        if (in_val && in_rdy) begin
            out_req <= rw_req;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_val && !out_rdy |=> out_val && $stable(out_req));

endmodule

`default_nettype wire

// File: hdl/tx_buf_wr_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "ip_rewrite_tx_defs.svh"

interface tx_buf_wr_if;
    import ip_rewrite_tx_pkg::*;

    logic                      req_val;
    logic                      req_rdy;
    logic [`TX_BUF_ADDR_W-1:0] req_addr;

    logic                      data_val;
    tx_buf_entry_t             data;
    logic                      data_last;
    logic                      data_rdy;

    logic                      done;
    logic                      done_rdy;

    modport writer (
        output req_val, data_val, data_last, done_rdy,
        input  req_rdy, data_rdy, done
    );

    modport datap (
        output req_addr, data
    );

    modport buffer (
        input  req_val, req_addr, data_val, data, data_last, done_rdy,
        output req_rdy, data_rdy, done
    );

endinterface

`default_nettype wire

// File: hdl/ip_rewrite_tx_pkg.sv
`default_nettype none

`include "ip_rewrite_tx_defs.svh"

package ip_rewrite_tx_pkg;

    // ####################
    // header and request
    // ####################
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] checksum;
        logic [15:0] length;
    } ip_hdr_t;

    typedef struct packed {
        logic [`FLOW_ID_W-1:0] flow_id;
        ip_hdr_t               hdr;
    } tx_req_t;

    // ####################
    // noc messages
    // ####################
    typedef enum logic {
        TX_REQ     = 1'b0,
        PTR_UPDATE = 1'b1
    } noc_msg_type_e;

    typedef struct packed {
        noc_msg_type_e         msg_type;
        logic [`FLOW_ID_W-1:0] flow_id;
        logic [15:0]           value;    // length or new tail pointer.
    } noc_msg_t;

    typedef enum logic {
        SEL_TX_REQ     = 1'b0,
        SEL_PTR_UPDATE = 1'b1
    } tx_noc_sel_e;

    typedef struct packed {
        logic [`FLOW_ID_W-1:0] flow_id;
        ip_hdr_t               hdr;      // header after rewrite.
    } tx_buf_entry_t;

endpackage

`default_nettype wire

// File: hdl/ip_rewrite_tx_defs.svh
`ifndef IP_REWRITE_TX_DEFS_SVH
`define IP_REWRITE_TX_DEFS_SVH

// ####################
// flow table sizing
// ####################
`define FLOW_ID_W       4
`define RW_TABLE_DEPTH  16

// ####################
// tx buffer sizing
// ####################
`define TX_BUF_DEPTH    16
`define TX_BUF_ADDR_W   4

`endif
